// ==== src/monitor_pkg.sv ====
package monitor_pkg;

    // ------------------------------------------------------------
    // Widths with a meaning on the bus and in the queue
    // ------------------------------------------------------------
    typedef logic [31:0] data_t;
    typedef logic [9:0]  addr_t;
    typedef logic [4:0]  csr_addr_t;

    // Fill level, one bit wider than the largest pointer
    typedef logic [8:0]  count_t;

    // ------------------------------------------------------------
    // Read port sequencer
    // ------------------------------------------------------------
    typedef enum logic {
        rd_idle,
        rd_ack
    } rd_state_t;

    // ------------------------------------------------------------
    // Register and read port offsets
    // ------------------------------------------------------------
    // Status on read, clear of irq and drop flag on write
    localparam csr_addr_t csr_status_offset = 5'd0;

    // Offset 1 pops the head entry when the read completes
    localparam addr_t rd_addr_word = 10'd0;
    localparam addr_t rd_data_word = 10'd1;

endpackage

// ==== src/capture_queue.sv ====
`timescale 1ns/1ps

module capture_queue #(
    parameter int FIFO_DEPTH      = 64,
    parameter int ALMOST_OVERFLOW = 56
) (
    input  logic                clk,
    input  logic                reset,

    input  logic                in_write,
    input  monitor_pkg::addr_t  in_address,
    input  monitor_pkg::data_t  in_writedata,

    input  logic                pop,
    input  logic                drop_clear,

    output monitor_pkg::addr_t  q_head_addr,
    output monitor_pkg::data_t  q_head_data,
    output monitor_pkg::count_t q_count,
    output logic                q_empty,
    output logic                q_full,
    output logic                q_almost_overflow,
    output logic                q_dropped
);
    import monitor_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(FIFO_DEPTH - 1);
    localparam count_t DEPTH_CNT  = count_t'(FIFO_DEPTH);
    localparam count_t THRESH_CNT = count_t'(ALMOST_OVERFLOW);

    // Parallel storage, one slot per captured transfer
    addr_t addr_mem [FIFO_DEPTH];
    data_t data_mem [FIFO_DEPTH];

    // head is the write slot, tail the oldest entry
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] head_next;
    logic [PTR_W-1:0] tail_next;
    count_t           count_next;

    logic do_capture;
    logic do_pop;
    logic drop_write;

    // ------------------------------------------------------------
    // Capture, drop and pop decisions
    // ------------------------------------------------------------
    assign do_capture = in_write & ~q_full;
    assign drop_write = in_write & q_full;
    assign do_pop     = pop & ~q_empty;

    assign head_next = do_capture ? ((head == LAST_IDX) ? '0 : head + 1'b1) : head;
    assign tail_next = do_pop ? ((tail == LAST_IDX) ? '0 : tail + 1'b1) : tail;

    always_comb begin
        case ({do_capture, do_pop})
            2'b10:   count_next = q_count + 1'b1;
            2'b01:   count_next = q_count - 1'b1;
            // Capture and pop together cancel out
            default: count_next = q_count;
        endcase
    end

    // ------------------------------------------------------------
    // Pointers and fill state
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
        end else begin
            head <= head_next;
            tail <= tail_next;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_count           <= '0;
            q_empty           <= 1'b1;
            q_full            <= 1'b0;
            q_almost_overflow <= 1'b0;
        end else begin
            q_count           <= count_next;
            q_empty           <= (count_next == '0);
            q_full            <= (count_next == DEPTH_CNT);
            q_almost_overflow <= (count_next >= THRESH_CNT);
        end
    end

    // Sticky until software clears it, a new drop wins
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_dropped <= 1'b0;
        end else if (drop_write) begin
            q_dropped <= 1'b1;
        end else if (drop_clear) begin
            q_dropped <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Storage and head register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_capture) begin
            addr_mem[head] <= in_address;
            data_mem[head] <= in_writedata;
        end
    end

    // Follows the new tail, bypassing a capture into an emptied queue
    always_ff @(posedge clk) begin
        if (do_capture && (head == tail_next)) begin
            q_head_addr <= in_address;
            q_head_data <= in_writedata;
        end else begin
            q_head_addr <= addr_mem[tail_next];
            q_head_data <= data_mem[tail_next];
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // Read side only pops what it has shown as present
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset) pop |-> !q_empty
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset) q_count <= DEPTH_CNT
    );

endmodule

// ==== src/monitor_read_port.sv ====
`timescale 1ns/1ps

module monitor_read_port (
    input  logic               clk,
    input  logic               reset,

    input  logic               out_read,
    input  monitor_pkg::addr_t out_address,

    input  monitor_pkg::addr_t q_head_addr,
    input  monitor_pkg::data_t q_head_data,
    input  logic               q_empty,

    output monitor_pkg::data_t out_readdata,
    output logic               out_waitrequest,
    output logic               pop
);
    import monitor_pkg::*;

    rd_state_t state;
    rd_state_t state_next;
    logic      rd_done;
    data_t     head_word;

    // ------------------------------------------------------------
    // Waitrequest sequencer
    // ------------------------------------------------------------
    // One wait cycle, then a single release cycle per read
    always_comb begin
        state_next = state;
        case (state)
            rd_idle: begin
                if (out_read) begin
                    state_next = rd_ack;
                end
            end
            rd_ack:  state_next = rd_idle;
            default: state_next = rd_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= rd_idle;
        end else begin
            state <= state_next;
        end
    end

    assign out_waitrequest = (state != rd_ack);
    assign rd_done         = out_read & (state == rd_ack);

    // ------------------------------------------------------------
    // Word select and pop
    // ------------------------------------------------------------
    always_comb begin
        case (out_address)
            rd_addr_word: head_word = data_t'(q_head_addr);
            rd_data_word: head_word = q_head_data;
            default:      head_word = '0;
        endcase
    end

    assign out_readdata = q_empty ? '0 : head_word;

    // Data word read retires the entry
    assign pop = rd_done & (out_address == rd_data_word) & ~q_empty;

    a_wait_single_release: assert property (
        @(posedge clk) disable iff (reset) !out_waitrequest |=> out_waitrequest
    );

endmodule

// ==== src/monitor_csr.sv ====
`timescale 1ns/1ps

module monitor_csr (
    input  logic                   clk,
    input  logic                   reset,

    input  monitor_pkg::csr_addr_t csr_address,
    input  logic                   csr_write,
    input  monitor_pkg::data_t     csr_writedata,
    input  logic                   csr_read,
    output monitor_pkg::data_t     csr_readdata,

    input  monitor_pkg::count_t    q_count,
    input  logic                   q_full,
    input  logic                   q_empty,
    input  logic                   q_almost_overflow,
    input  logic                   q_dropped,

    output logic                   irq,
    output logic                   drop_clear
);
    import monitor_pkg::*;

    logic  almost_d;
    logic  almost_rise;
    logic  clear_wr;
    data_t status_word;

    // ------------------------------------------------------------
    // Interrupt
    // ------------------------------------------------------------
    assign almost_rise = q_almost_overflow & ~almost_d;
    assign clear_wr    = csr_write & (csr_address == csr_status_offset);
    assign drop_clear  = clear_wr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            almost_d <= 1'b0;
        end else begin
            almost_d <= q_almost_overflow;
        end
    end

    // A fresh crossing beats a clear in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            irq <= 1'b0;
        end else if (almost_rise) begin
            irq <= 1'b1;
        end else if (clear_wr) begin
            irq <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Status readback
    // ------------------------------------------------------------
    always_comb begin
        status_word        = '0;
        status_word[8:0]   = q_count;
        status_word[9]     = q_full;
        status_word[10]    = q_empty;
        status_word[11]    = q_almost_overflow;
        status_word[12]    = q_dropped;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            csr_readdata <= '0;
        end else if (csr_read) begin
            if (csr_address == csr_status_offset) begin
                csr_readdata <= status_word;
            end else begin
                csr_readdata <= '0;
            end
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // Only a threshold crossing in the queue may raise irq
    a_irq_needs_edge: assert property (
        @(posedge clk) disable iff (reset) $rose(irq) |-> $past(almost_rise)
    );

endmodule

// ==== src/monitor_top.sv ====
`timescale 1ns/1ps

module monitor_top #(
    parameter int FIFO_DEPTH      = 64,
    parameter int ALMOST_OVERFLOW = 56
) (
    input  logic                   clk,
    input  logic                   reset,

    // ------------------------------------------------------------
    // Snooped write port
    // ------------------------------------------------------------
    input  monitor_pkg::data_t     in_writedata,
    input  logic                   in_write,
    input  monitor_pkg::addr_t     in_address,
    output logic                   in_waitrequest,

    // ------------------------------------------------------------
    // Queue read port
    // ------------------------------------------------------------
    input  logic                   out_read,
    input  monitor_pkg::addr_t     out_address,
    output monitor_pkg::data_t     out_readdata,
    output logic                   out_waitrequest,
    output logic                   empty,

    // ------------------------------------------------------------
    // Status and control registers
    // ------------------------------------------------------------
    input  monitor_pkg::csr_addr_t csr_address,
    input  logic                   csr_write,
    input  monitor_pkg::data_t     csr_writedata,
    input  logic                   csr_read,
    output monitor_pkg::data_t     csr_readdata,
    output logic                   irq
);
    import monitor_pkg::*;

    // Queue state shared by the read and register sides
    addr_t  q_head_addr;
    data_t  q_head_data;
    count_t q_count;
    logic   q_empty;
    logic   q_full;
    logic   q_almost_overflow;
    logic   q_dropped;

    logic   pop;
    logic   drop_clear;

    // Snooping never holds off the bus master
    assign in_waitrequest = 1'b0;
    assign empty          = q_empty;

    capture_queue #(
        .FIFO_DEPTH        (FIFO_DEPTH),
        .ALMOST_OVERFLOW   (ALMOST_OVERFLOW)
    ) u_queue (
        .clk               (clk),
        .reset             (reset),
        .in_write          (in_write),
        .in_address        (in_address),
        .in_writedata      (in_writedata),
        .pop               (pop),
        .drop_clear        (drop_clear),
        .q_head_addr       (q_head_addr),
        .q_head_data       (q_head_data),
        .q_count           (q_count),
        .q_empty           (q_empty),
        .q_full            (q_full),
        .q_almost_overflow (q_almost_overflow),
        .q_dropped         (q_dropped)
    );

    monitor_read_port u_read_port (
        .clk               (clk),
        .reset             (reset),
        .out_read          (out_read),
        .out_address       (out_address),
        .q_head_addr       (q_head_addr),
        .q_head_data       (q_head_data),
        .q_empty           (q_empty),
        .out_readdata      (out_readdata),
        .out_waitrequest   (out_waitrequest),
        .pop               (pop)
    );

    monitor_csr u_csr (
        .clk               (clk),
        .reset             (reset),
        .csr_address       (csr_address),
        .csr_write         (csr_write),
        .csr_writedata     (csr_writedata),
        .csr_read          (csr_read),
        .csr_readdata      (csr_readdata),
        .q_count           (q_count),
        .q_full            (q_full),
        .q_empty           (q_empty),
        .q_almost_overflow (q_almost_overflow),
        .q_dropped         (q_dropped),
        .irq               (irq),
        .drop_clear        (drop_clear)
    );

endmodule

// ==== dv/monitor_tb_tasks.svh ====
`ifndef MONITOR_TB_TASKS_SVH
`define MONITOR_TB_TASKS_SVH

// ------------------------------------------------------------
// Compare tasks and test bookkeeping
// ------------------------------------------------------------
task automatic compare_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
        error_count++;
        $display("MISMATCH @%0t ns: %s got 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
endtask

task automatic compare_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
        error_count++;
        $display("MISMATCH @%0t ns: %s got 0x%03h, expected 0x%03h", $time, what, got, exp);
    end
endtask

task automatic compare_status(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
        error_count++;
        $display("MISMATCH @%0t ns: %s got status 0x%04h, expected 0x%04h",
                 $time, what, got, exp);
    end
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        error_count++;
        $display("MISMATCH @%0t ns: %s got %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic begin_test();
    test_start_errors = error_count;
endtask

task automatic end_test(input string name);
    if (error_count == test_start_errors) begin
        $display("[%0t ns] %s: passed", $time, name);
    end else begin
        tests_failed++;
        $display("[%0t ns] %s: FAILED with %0d errors", $time, name,
                 error_count - test_start_errors);
    end
endtask

// Status word as the register layout defines it, from the model
function automatic data_t expected_status();
    data_t st;
    st = '0;
    st[8:0] = count_t'(model_addr.size());
    st[9] = (model_addr.size() == FIFO_DEPTH);
    st[10] = (model_addr.size() == 0);
    st[11] = (model_addr.size() >= ALMOST_OVERFLOW);
    st[12] = exp_dropped;
    return st;
endfunction

// ------------------------------------------------------------
// Bus drivers, all start and end 1 ns after a rising edge
// ------------------------------------------------------------
task automatic snoop_random_write();
    in_address = addr_t'($urandom);
    in_writedata = $urandom;
    in_write = 1'b1;
    if (model_addr.size() < FIFO_DEPTH) begin
        model_addr.push_back(in_address);
        model_data.push_back(in_writedata);
    end else begin
        exp_dropped = 1'b1;
    end
    @(posedge clk);
    #1;
    in_write = 1'b0;
endtask

// Optional capture lands in the completing cycle of the read
task automatic read_word(input addr_t offset, input logic with_capture, output data_t rdata);
    int waits;
    waits = 0;
    out_address = offset;
    out_read = 1'b1;
    @(negedge clk);
    while (out_waitrequest && waits < 8) begin
        waits++;
        @(posedge clk);
        #1;
        in_write = with_capture && (waits == 1);
        @(negedge clk);
    end
    rdata = out_readdata;
    if (waits != 1) begin
        error_count++;
        $display("[%0t ns] read handshake took %0d wait cycles instead of one", $time, waits);
    end
    @(posedge clk);
    #1;
    out_read = 1'b0;
    in_write = 1'b0;
endtask

task automatic read_entry(input logic with_capture);
    data_t rdata;
    addr_t exp_addr;
    data_t exp_data;
    exp_addr = model_addr.pop_front();
    exp_data = model_data.pop_front();
    read_word(rd_addr_word, 1'b0, rdata);
    compare_addr(addr_t'(rdata), exp_addr, "head address");
    if (with_capture) begin
        in_address = addr_t'($urandom);
        in_writedata = $urandom;
        model_addr.push_back(in_address);
        model_data.push_back(in_writedata);
    end
    read_word(rd_data_word, with_capture, rdata);
    compare_data(rdata, exp_data, "head data");
endtask

task automatic drain_queue();
    while (model_addr.size() > 0) begin
        read_entry(1'b0);
    end
endtask

task automatic check_status(input string what);
    csr_address = csr_status_offset;
    csr_read = 1'b1;
    @(posedge clk);
    #1;
    compare_status(csr_readdata, expected_status(), what);
    csr_read = 1'b0;
endtask

// Clears irq and the drop flag
task automatic clear_status();
    csr_address = csr_status_offset;
    csr_writedata = '0;
    csr_write = 1'b1;
    @(posedge clk);
    #1;
    csr_write = 1'b0;
    exp_dropped = 1'b0;
endtask

// ------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------
task automatic reset_defaults();
    data_t rdata;
    begin_test();
    compare_bit(empty, 1'b1, "empty after reset");
    compare_bit(irq, 1'b0, "irq after reset");
    compare_bit(in_waitrequest, 1'b0, "snoop waitrequest");
    check_status("status after reset");
    read_word(rd_data_word, 1'b0, rdata);
    compare_data(rdata, '0, "data word of empty queue");
    check_status("status after empty read");
    end_test("reset_defaults");
endtask

task automatic ordered_readback();
    begin_test();
    repeat (5) snoop_random_write();
    check_status("status after five writes");
    repeat (5) begin
        read_entry(1'b0);
        check_status("status after pop");
    end
    end_test("ordered_readback");
endtask

// One wait cycle, one release cycle, then high again
task automatic waitrequest_timing();
    begin_test();
    snoop_random_write();
    out_address = rd_addr_word;
    out_read = 1'b1;
    @(negedge clk);
    compare_bit(out_waitrequest, 1'b1, "waitrequest in wait cycle");
    @(negedge clk);
    compare_bit(out_waitrequest, 1'b0, "waitrequest in release cycle");
    @(posedge clk);
    #1;
    out_read = 1'b0;
    @(negedge clk);
    compare_bit(out_waitrequest, 1'b1, "waitrequest after completion");
    @(posedge clk);
    #1;
    drain_queue();
    end_test("waitrequest_timing");
endtask

task automatic irq_threshold();
    int waited;
    begin_test();
    while (model_addr.size() < ALMOST_OVERFLOW) snoop_random_write();
    waited = 0;
    while (!irq && waited < 3) begin
        @(posedge clk);
        #1;
        waited++;
    end
    compare_bit(irq, 1'b1, "irq after threshold");
    check_status("status at threshold");
    clear_status();
    compare_bit(irq, 1'b0, "irq after clear");
    snoop_random_write();
    repeat (3) @(posedge clk);
    #1;
    compare_bit(irq, 1'b0, "irq above threshold after clear");
    check_status("status above threshold");
    end_test("irq_threshold");
endtask

task automatic overflow_drop();
    begin_test();
    repeat (FIFO_DEPTH - model_addr.size() + 2) snoop_random_write();
    check_status("status after overflow");
    drain_queue();
    check_status("status after drain");
    clear_status();
    check_status("status after drop clear");
    end_test("overflow_drop");
endtask

// Enough traffic to wrap both pointers more than twice
task automatic pointer_wraparound();
    int i;
    begin_test();
    for (i = 0; i < 30; i++) begin
        snoop_random_write();
        if (model_addr.size() >= 4) begin
            read_entry((i % 3) == 0);
        end
        check_status("status during interleave");
    end
    drain_queue();
    check_status("status after wraparound drain");
    end_test("pointer_wraparound");
endtask

`endif

// ==== dv/monitor_tb.sv ====
`timescale 1ns/1ps

module monitor_tb;
    import monitor_pkg::*;

    localparam int FIFO_DEPTH      = 16;
    localparam int ALMOST_OVERFLOW = 12;
    localparam int NUM_TESTS       = 6;
    localparam int WATCHDOG_NS     = NUM_TESTS * 2000;
    localparam logic [31:0] RNG_SEED = 32'hbcf0_a5f6;

    logic      clk = 1'b0;
    logic      reset;
    data_t     in_writedata;
    logic      in_write;
    addr_t     in_address;
    logic      in_waitrequest;
    logic      out_read;
    addr_t     out_address;
    data_t     out_readdata;
    logic      out_waitrequest;
    logic      empty;
    csr_addr_t csr_address;
    logic      csr_write;
    data_t     csr_writedata;
    logic      csr_read;
    data_t     csr_readdata;
    logic      irq;

    // Reference queue and result counters
    addr_t model_addr[$];
    data_t model_data[$];
    logic  exp_dropped = 1'b0;
    int    error_count = 0;
    int    tests_failed = 0;
    int    test_start_errors = 0;

    monitor_top #(
        .FIFO_DEPTH      (FIFO_DEPTH),
        .ALMOST_OVERFLOW (ALMOST_OVERFLOW)
    ) DUT (
        .clk             (clk),
        .reset           (reset),
        .in_writedata    (in_writedata),
        .in_write        (in_write),
        .in_address      (in_address),
        .in_waitrequest  (in_waitrequest),
        .out_read        (out_read),
        .out_address     (out_address),
        .out_readdata    (out_readdata),
        .out_waitrequest (out_waitrequest),
        .empty           (empty),
        .csr_address     (csr_address),
        .csr_write       (csr_write),
        .csr_writedata   (csr_writedata),
        .csr_read        (csr_read),
        .csr_readdata    (csr_readdata),
        .irq             (irq)
    );

    always #2 clk = ~clk;

    `include "monitor_tb_tasks.svh"

    // Upper bound on the whole run
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        in_writedata = '0;
        in_write = 1'b0;
        in_address = '0;
        out_read = 1'b0;
        out_address = '0;
        csr_address = '0;
        csr_write = 1'b0;
        csr_writedata = '0;
        csr_read = 1'b0;
        void'($urandom(RNG_SEED));
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_defaults();
        ordered_readback();
        waitrequest_timing();
        irq_threshold();
        overflow_drop();
        pointer_wraparound();

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 NUM_TESTS, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+dv
src/monitor_pkg.sv
src/capture_queue.sv
src/monitor_read_port.sv
src/monitor_csr.sv
src/monitor_top.sv
dv/monitor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module monitor_tb -f compile.f -o monitor_sim || exit 1
sim_out=$(./obj_dir/monitor_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "Simulation completed successfully" && exit 0 || exit 1
